// File: hw/slm_link_settings.svh
`ifndef SLM_LINK_SETTINGS_SVH
`define SLM_LINK_SETTINGS_SVH

// uart bit period in sys_clk cycles
// short value for simulation, board build uses 100 MHz / 115200
`define SLM_CLKS_PER_BIT 8

// sys_clk cycles per half sck period
`define SLM_SPI_HALF_PERIOD 2

// display reset hold after the reset command, in cycles
`define SLM_RESET_HOLD 10

// reply queue entries
`define SLM_QUEUE_DEPTH 4

`endif

// File: hw/slm_link_pkg.sv
package slm_link_pkg;

  // one byte on the uart or on the spi wire
  typedef logic [7:0] byte_t;

  // one 16 bit spi frame
  // address byte sits in the upper half and goes out first
  // the display answers during the lower half
  typedef struct packed {
    byte_t addr;
    byte_t data;
  } spi_word_t;

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/1ns
`include "slm_link_settings.svh"

module uart_rx (
  input  logic                sys_clk,
  input  logic                reset_all_cmd_w,
  input  logic                serial_i,
  output logic                rx_valid_o,
  output slm_link_pkg::byte_t rx_byte_o
);

  localparam int CLKS = `SLM_CLKS_PER_BIT;
  localparam int CW   = $clog2(CLKS + 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t           state_q;
  logic [CW-1:0]       clk_cnt_q;
  logic [2:0]          bit_cnt_q;
  logic [1:0]          sync_q;
  logic                line_w;
  slm_link_pkg::byte_t shift_q;

  // two flop sync, host line is async to sys_clk
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], serial_i};
    end
  end

  assign line_w = sync_q[1];

  //////////////////////////////////////////////////
  // frame fsm
  //////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    // strobe is one cycle wide
    rx_valid_o <= 1'b0;
    if (reset_all_cmd_w) begin
      state_q   <= RX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          bit_cnt_q <= '0;
          // falling edge marks a start bit
          if (!line_w) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // recheck at mid start bit, glitches go back to idle
          if (clk_cnt_q == CW'(CLKS / 2 - 1)) begin
            clk_cnt_q <= '0;
            state_q   <= line_w ? RX_IDLE : RX_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (clk_cnt_q == CW'(CLKS - 1)) begin
            clk_cnt_q <= '0;
            // lsb first, shift in from the top
            shift_q   <= {line_w, shift_q[7:1]};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          // mid stop bit, bad stop drops the frame
          if (clk_cnt_q == CW'(CLKS - 1)) begin
            clk_cnt_q  <= '0;
            rx_valid_o <= line_w;
            state_q    <= RX_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // shift reg holds the byte until the next frame's data bits
  assign rx_byte_o = shift_q;

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/1ns
`include "slm_link_settings.svh"

module uart_tx (
  input  logic                sys_clk,
  input  logic                reset_all_cmd_w,
  input  logic                tx_start_i,
  input  slm_link_pkg::byte_t tx_byte_i,
  output logic                tx_busy_o,
  output logic                serial_o
);

  localparam int CLKS = `SLM_CLKS_PER_BIT;
  localparam int CW   = $clog2(CLKS + 1);

  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

  tx_state_t           state_q;
  logic [CW-1:0]       clk_cnt_q;
  logic [2:0]          bit_cnt_q;
  logic                baud_tick_w;
  slm_link_pkg::byte_t shift_q;

  // last cycle of the current bit
  assign baud_tick_w = (clk_cnt_q == CW'(CLKS - 1));

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= TX_IDLE;
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      tx_busy_o <= 1'b0;
      // line idles high
      serial_o  <= 1'b1;
    end else begin
      // baud counter only runs inside a frame
      if (state_q != TX_IDLE) begin
        clk_cnt_q <= baud_tick_w ? '0 : clk_cnt_q + 1'b1;
      end
      case (state_q)
        TX_IDLE: begin
          clk_cnt_q <= '0;
          bit_cnt_q <= '0;
          serial_o  <= 1'b1;
          if (tx_start_i) begin
            shift_q   <= tx_byte_i;
            tx_busy_o <= 1'b1;
            // start bit goes out right away
            serial_o  <= 1'b0;
            state_q   <= TX_START;
          end
        end
        TX_START: begin
          if (baud_tick_w) begin
            serial_o <= shift_q[0];
            shift_q  <= shift_q >> 1;
            state_q  <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (baud_tick_w) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              // stop bit
              serial_o <= 1'b1;
              state_q  <= TX_STOP;
            end else begin
              serial_o <= shift_q[0];
              shift_q  <= shift_q >> 1;
            end
          end
        end
        default: begin
          // busy drops at the very end of the stop bit
          if (baud_tick_w) begin
            tx_busy_o <= 1'b0;
            state_q   <= TX_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// File: hw/spi_master.sv
`timescale 1ns/1ns
`include "slm_link_settings.svh"

module spi_master (
  input  logic                    sys_clk,
  input  logic                    reset_all_cmd_w,
  input  logic                    start_i,
  input  slm_link_pkg::spi_word_t word_i,
  input  logic                    sdat_i,
  output logic                    sen_o,
  output logic                    sck_o,
  output logic                    sdat_o,
  output logic                    done_o,
  output slm_link_pkg::byte_t     rx_byte_o
);

  localparam int HALF = `SLM_SPI_HALF_PERIOD;
  localparam int HW   = $clog2(HALF + 1);

  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_TAIL} spi_state_t;

  spi_state_t          state_q;
  logic [HW-1:0]       half_cnt_q;
  logic [3:0]          bit_cnt_q;
  logic                half_tick_w;
  logic [15:0]         tx_shift_q;
  slm_link_pkg::byte_t rx_shift_q;

  assign half_tick_w = (half_cnt_q == HW'(HALF - 1));

  //////////////////////////////////////////////////
  // sck divider and shifter
  //////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    done_o <= 1'b0;
    if (reset_all_cmd_w) begin
      state_q    <= SPI_IDLE;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      sen_o      <= 1'b1;
      sck_o      <= 1'b0;
      sdat_o     <= 1'b0;
    end else begin
      if (state_q != SPI_IDLE) begin
        half_cnt_q <= half_tick_w ? '0 : half_cnt_q + 1'b1;
      end
      case (state_q)
        SPI_IDLE: begin
          half_cnt_q <= '0;
          bit_cnt_q  <= '0;
          // starts while busy are ignored
          if (start_i) begin
            tx_shift_q <= word_i;
            sen_o      <= 1'b0;
            // msb of the address is set up before the first rising edge
            sdat_o     <= word_i.addr[7];
            state_q    <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          if (half_tick_w) begin
            sck_o <= ~sck_o;
            if (!sck_o) begin
              // rising edge, chip answer is shifted in
              rx_shift_q <= {rx_shift_q[6:0], sdat_i};
            end else if (bit_cnt_q == 4'd15) begin
              // last falling edge, sck parks low
              state_q <= SPI_TAIL;
            end else begin
              // falling edge, next bit out
              bit_cnt_q  <= bit_cnt_q + 1'b1;
              sdat_o     <= tx_shift_q[14];
              tx_shift_q <= {tx_shift_q[14:0], 1'b0};
            end
          end
        end
        default: begin
          // half period of hold before sen goes back up
          if (half_tick_w) begin
            sen_o     <= 1'b1;
            done_o    <= 1'b1;
            // last 8 captured bits are the lower half reply
            rx_byte_o <= rx_shift_q;
            state_q   <= SPI_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// File: hw/link_regs.sv
`timescale 1ns/1ns
`include "slm_link_settings.svh"

module link_regs (
  input  logic                    sys_clk,
  input  logic                    reset_all_cmd_w,
  input  logic                    rx_valid_i,
  input  slm_link_pkg::byte_t     rx_byte_i,
  output logic                    spi_start_o,
  output slm_link_pkg::spi_word_t spi_word_o,
  output logic                    slm_reset_n_o
);

  localparam int HOLD = `SLM_RESET_HOLD;
  localparam int RW   = $clog2(HOLD + 1);

  slm_link_pkg::spi_word_t word_q;
  logic                    second_q;
  logic [RW-1:0]           hold_cnt_q;

  //////////////////////////////////////////////////
  // byte pairing
  //////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    spi_start_o <= 1'b0;
    if (reset_all_cmd_w) begin
      // next byte is the first of a pair
      second_q <= 1'b0;
    end else if (rx_valid_i) begin
      // old data byte becomes the address, new byte is data
      word_q.addr <= word_q.data;
      word_q.data <= rx_byte_i;
      second_q    <= ~second_q;
      // only every second byte fires a transfer
      spi_start_o <= second_q;
    end
  end

  assign spi_word_o = word_q;

  //////////////////////////////////////////////////
  // display reset stretcher
  //////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt_q    <= RW'(HOLD);
      slm_reset_n_o <= 1'b0;
    end else if (hold_cnt_q != '0) begin
      // keep the chip in reset while counting down
      hold_cnt_q    <= hold_cnt_q - 1'b1;
      slm_reset_n_o <= 1'b0;
    end else begin
      slm_reset_n_o <= 1'b1;
    end
  end

endmodule

// File: hw/reply_queue.sv
`timescale 1ns/1ns
`include "slm_link_settings.svh"

module reply_queue (
  input  logic                sys_clk,
  input  logic                reset_all_cmd_w,
  input  logic                wr_en_i,
  input  slm_link_pkg::byte_t wr_byte_i,
  input  logic                tx_busy_i,
  output logic                tx_start_o,
  output slm_link_pkg::byte_t tx_byte_o
);

  localparam int DEPTH = `SLM_QUEUE_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  slm_link_pkg::byte_t mem_q [DEPTH];
  logic [AW-1:0]       wr_ptr_q;
  logic [AW-1:0]       rd_ptr_q;
  logic [CW-1:0]       count_q;
  logic                full_w;
  logic                empty_w;
  logic                push_w;
  logic                pop_w;

  assign full_w  = (count_q == CW'(DEPTH));
  assign empty_w = (count_q == '0);
  // reply lost when full
  assign push_w  = wr_en_i && !full_w;
  // uart busy rises a cycle after tx_start, so block on tx_start too
  assign pop_w   = !empty_w && !tx_busy_i && !tx_start_o;

  //////////////////////////////////////////////////
  // pointers and fill level
  //////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_start_o <= 1'b0;
    end else begin
      if (push_w) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_w) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_w, pop_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // uart launch one cycle after the pop
      tx_start_o <= pop_w;
    end
  end

  // storage and output byte
  always_ff @(posedge sys_clk) begin
    if (push_w) begin
      mem_q[wr_ptr_q] <= wr_byte_i;
    end
    if (pop_w) begin
      tx_byte_o <= mem_q[rd_ptr_q];
    end
  end

endmodule

// File: hw/slm_link_top.sv
`timescale 1ns/1ns

module slm_link_top (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  input  logic spi_sout_i,
  output logic slm_reset_n_o
);

  // host byte in
  logic                    rx_valid;
  slm_link_pkg::byte_t     rx_byte;
  // paired frame to the display
  logic                    spi_start;
  slm_link_pkg::spi_word_t spi_word;
  // display answer
  logic                    spi_done;
  slm_link_pkg::byte_t     spi_rx_byte;
  // echo back to host
  logic                    tx_start;
  slm_link_pkg::byte_t     tx_byte;
  logic                    tx_busy;

  //////////////////////////////////////////////////
  // host to display
  //////////////////////////////////////////////////
  uart_rx u_uart_rx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .serial_i        (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  link_regs u_link_regs (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_start_o     (spi_start),
    .spi_word_o      (spi_word),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  spi_master u_spi_master (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .start_i         (spi_start),
    .word_i          (spi_word),
    .sdat_i          (spi_sout_i),
    .sen_o           (spi_sen_o),
    .sck_o           (spi_sck_o),
    .sdat_o          (spi_sdat_o),
    .done_o          (spi_done),
    .rx_byte_o       (spi_rx_byte)
  );

  //////////////////////////////////////////////////
  // display answer back to host
  //////////////////////////////////////////////////
  reply_queue u_reply_queue (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .wr_en_i         (spi_done),
    .wr_byte_i       (spi_rx_byte),
    .tx_busy_i       (tx_busy),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx u_uart_tx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_busy_o       (tx_busy),
    .serial_o        (uart_tx_o)
  );

endmodule

// File: testbench/slm_link_checker.sv
`timescale 1ns/1ns
`include "slm_link_settings.svh"

module slm_link_checker (
  input logic sys_clk,
  input logic reset_all_cmd_w,
  input logic sen_i,
  input logic sck_i,
  input logic sdat_i,
  input logic slm_reset_n_i,
  input logic uart_tx_i
);

  localparam int HOLD = `SLM_RESET_HOLD;
  localparam int HALF = `SLM_SPI_HALF_PERIOD;

  // read by the testbench at the end of the run
  int fail_cnt = 0;

  //////////////////////////////////////////////////
  // display reset stretch
  //////////////////////////////////////////////////
  // still low on the last cycle of the hold
  a_reset_hold: assert property (@(posedge sys_clk)
    $fell(reset_all_cmd_w) |-> ##HOLD !slm_reset_n_i)
  else begin
    fail_cnt++;
    $error("display reset released before the hold ended");
  end

  // and released right after it
  a_reset_release: assert property (@(posedge sys_clk)
    $fell(reset_all_cmd_w) |-> ##(HOLD + 1) slm_reset_n_i)
  else begin
    fail_cnt++;
    $error("display reset not released after the hold");
  end

  // idle levels while the reset command is active
  a_reset_idle: assert property (@(posedge sys_clk)
    reset_all_cmd_w |=> !slm_reset_n_i && sen_i && uart_tx_i && !sck_i)
  else begin
    fail_cnt++;
    $error("outputs not at idle level during reset");
  end

  //////////////////////////////////////////////////
  // spi wire protocol
  //////////////////////////////////////////////////
  // sck parks low outside a frame
  a_sck_idle: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    sen_i |-> !sck_i)
  else begin
    fail_cnt++;
    $error("sck high while sen is high");
  end

  // no toggle next to a sen edge either
  a_sck_framed: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    !$stable(sck_i) |-> !sen_i && !$past(sen_i))
  else begin
    fail_cnt++;
    $error("sck toggled outside the sen window");
  end

  // data held one cycle before and after each rising edge
  a_sdat_stable: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    $rose(sck_i) |-> $stable(sdat_i) ##1 $stable(sdat_i))
  else begin
    fail_cnt++;
    $error("sdat moved around an sck rising edge");
  end

  // high phase lasts one half period
  a_sck_half: assert property (@(posedge sys_clk) disable iff (reset_all_cmd_w)
    $rose(sck_i) |-> ##(HALF - 1) sck_i ##1 !sck_i)
  else begin
    fail_cnt++;
    $error("sck high phase has the wrong length");
  end

endmodule

// File: testbench/tb_top.sv
`timescale 1ns/1ns
`include "slm_link_settings.svh"

module tb_top;

  localparam int CLKS      = `SLM_CLKS_PER_BIT;
  localparam int HOLD      = `SLM_RESET_HOLD;
  localparam int PERIOD    = 100;
  localparam int NUM_TESTS = 5;
  localparam int NUM_PAIRS = 4;
  // host bytes plus echoed replies
  localparam int NUM_FRAMES = (2 + 2 * NUM_PAIRS) + (1 + NUM_PAIRS);
  localparam int FRAME_CYC  = 10 * CLKS;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic uart_tx_o;
  logic spi_sen_o;
  logic spi_sck_o;
  logic spi_sdat_o;
  logic spi_sout_i;
  logic slm_reset_n_o;

  logic [31:0] lcg_state = 32'h2b54_8879;
  int          err_cnt = 0;
  int          tests_failed = 0;
  int          tests_run = 0;

  // slave model state
  logic [15:0] slave_shift;
  logic [15:0] mosi_shift;
  logic [7:0]  pending_reply;
  logic        sck_prev;
  logic        sen_prev;
  int          rise_cnt;
  logic [15:0] frames_q [$];
  logic [7:0]  exp_reply_q [$];
  logic [7:0]  host_rx_q [$];

  slm_link_top DUT (.*);

  bind slm_link_top slm_link_checker u_checker (
    .sys_clk       (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .sen_i         (spi_sen_o),
    .sck_i         (spi_sck_o),
    .sdat_i        (spi_sdat_o),
    .slm_reset_n_i (slm_reset_n_o),
    .uart_tx_i     (uart_tx_o)
  );

  always #(PERIOD / 2) sys_clk = ~sys_clk;

  function automatic logic [7:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic expect_true(input logic ok, input string msg);
    assert (ok) else begin
      err_cnt++;
      $display("** Error at %0t ns: %s", $time, msg);
    end
  endtask

  // one 8N1 frame onto the host line
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    @(posedge sys_clk);
    for (int i = 0; i < 10; i++) begin
      uart_rx_i <= bits[i];
      repeat (CLKS) @(posedge sys_clk);
    end
  endtask

  task automatic wait_count(input int want, input bit use_frames, input string what);
    int n;
    n = 0;
    while ((use_frames ? frames_q.size() : host_rx_q.size()) < want && n < 8 * FRAME_CYC) begin
      @(posedge sys_clk);
      n++;
    end
    expect_true(n < 8 * FRAME_CYC, {"timed out waiting for ", what});
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED", tests_run, name);
    end
  endtask

  //////////////////////////////////////////////////
  // spi slave model
  //////////////////////////////////////////////////
  always @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      // bus counts as idle until the reset command ends
      sck_prev <= 1'b0;
      sen_prev <= 1'b1;
    end else begin
      sck_prev <= spi_sck_o;
      sen_prev <= spi_sen_o;
      if (spi_sen_o) begin
        // filler in the upper half and the reply in the lower half
        slave_shift <= {~pending_reply, pending_reply};
        spi_sout_i  <= ~pending_reply[7];
        if (!sen_prev) begin
          frames_q.push_back(mosi_shift);
          expect_true(rise_cnt == 16, "spi frame without 16 sck rising edges");
          pending_reply = next_rand();
        end
      end else begin
        if (sen_prev) begin
          exp_reply_q.push_back(pending_reply);
          rise_cnt = 0;
        end
        if (spi_sck_o && !sck_prev) begin
          mosi_shift <= {mosi_shift[14:0], spi_sdat_o};
          rise_cnt++;
        end
        if (!spi_sck_o && sck_prev) begin
          slave_shift <= {slave_shift[14:0], 1'b0};
          spi_sout_i  <= slave_shift[14];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // host receiver on uart_tx_o
  //////////////////////////////////////////////////
  initial begin
    logic [7:0] b;
    forever begin
      @(posedge sys_clk);
      if (!reset_all_cmd_w && !uart_tx_o) begin
        // middle of the start bit
        repeat (CLKS / 2) @(posedge sys_clk);
        expect_true(!uart_tx_o, "uart start bit too short");
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS) @(posedge sys_clk);
          b[i] = uart_tx_o;
        end
        repeat (CLKS) @(posedge sys_clk);
        expect_true(uart_tx_o, "uart stop bit missing");
        host_rx_q.push_back(b);
      end
    end
  end

  // watchdog
  initial begin
    #(NUM_FRAMES * 12 * CLKS * PERIOD * NUM_TESTS + 20000);
    $display("watchdog: the run did not finish in time");
    $display("test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    int          e0;
    int          low_cnt;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [15:0] exp_frames [$];
    sys_clk = 1'b0;
    reset_all_cmd_w <= 1'b1;
    uart_rx_i       <= 1'b1;
    spi_sout_i      <= 1'b0;
    mosi_shift      <= '0;
    rise_cnt = 0;
    pending_reply = next_rand();

    // test 1 reset stretch and idle levels
    e0 = err_cnt;
    repeat (3) @(posedge sys_clk);
    reset_all_cmd_w <= 1'b0;
    @(posedge sys_clk);
    low_cnt = 0;
    @(posedge sys_clk);
    while (!slm_reset_n_o && low_cnt < 4 * HOLD) begin
      low_cnt++;
      @(posedge sys_clk);
    end
    expect_true(low_cnt == HOLD, "display reset low for the wrong number of cycles");
    expect_true(spi_sen_o && uart_tx_o, "sen or uart tx not high after reset");
    report_test("reset stretch", e0);

    // test 2 one byte starts no transfer
    e0 = err_cnt;
    a = next_rand();
    send_byte(a);
    for (int i = 0; i < 2 * FRAME_CYC + 4; i++) begin
      @(posedge sys_clk);
      expect_true(spi_sen_o, "sen dropped after a single host byte");
    end
    expect_true(frames_q.size() == 0, "spi frame after a single host byte");
    report_test("single byte", e0);

    // test 3 second byte sends one frame A then B
    e0 = err_cnt;
    b = next_rand();
    send_byte(b);
    wait_count(1, 1'b1, "spi frame");
    expect_true(frames_q.size() == 1 && frames_q[0] == {a, b}, "spi frame bits wrong");
    wait_count(1, 1'b0, "uart reply");
    expect_true(host_rx_q.size() == 1 && host_rx_q[0] == exp_reply_q[0], "reply byte wrong");
    report_test("byte pair", e0);

    // test 4 spi wire protocol seen by the bound assertions
    e0 = err_cnt;
    expect_true(DUT.u_checker.fail_cnt == 0, "spi protocol assertion failed");
    report_test("spi protocol", e0);

    // test 5 back to back pairs with replies in order
    e0 = err_cnt;
    for (int p = 0; p < NUM_PAIRS; p++) begin
      a = next_rand();
      b = next_rand();
      exp_frames.push_back({a, b});
      send_byte(a);
      send_byte(b);
    end
    wait_count(1 + NUM_PAIRS, 1'b1, "spi frames");
    wait_count(1 + NUM_PAIRS, 1'b0, "uart replies");
    for (int p = 0; p < NUM_PAIRS; p++) begin
      expect_true(frames_q[1 + p] == exp_frames[p], "spi frame bits wrong in burst");
      expect_true(host_rx_q[1 + p] == exp_reply_q[1 + p], "reply out of order or wrong");
    end
    report_test("reply order", e0);

    repeat (4 * CLKS) @(posedge sys_clk);
    if (DUT.u_checker.fail_cnt != 0) begin
      err_cnt += DUT.u_checker.fail_cnt;
    end
    $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    if (err_cnt == 0 && tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hw
hw/slm_link_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/spi_master.sv
hw/link_regs.sv
hw/reply_queue.sv
hw/slm_link_top.sv
testbench/slm_link_checker.sv
testbench/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_top
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
